// File: project.f
+incdir+src
+incdir+sim
src/sd_readout_pkg.sv
src/datin_block_capture.sv
src/readout_fifo.sv
src/qspi_cmd_engine.sv
src/sd_readout_top.sv
sim/tb_sd_readout.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; $fatal gives a failing exit status
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tb_sd_readout -o tb_sd_readout &&
./obj_dir/tb_sd_readout || exit 1

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==================================================
// Random numbers
// ==================================================

function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

function automatic logic [55:0] rand_arg();
    logic [63:0] both;
    both = {rand32(), rand32()};
    return both[55:0];
endfunction

// ==================================================
// Host side
// ==================================================

// Type code and argument high nibble first with quiet lines after
task automatic send_msg(input logic [7:0] code, input logic [55:0] arg);
    logic [63:0] bits;
    bits = {code, arg};
    for (int i = 15; i >= 0; i--) begin
        @(posedge sd_datInWrite_clk);
        spi_d_in <= bits[i*4 +: 4];
    end
    @(posedge sd_datInWrite_clk);
    spi_d_in <= 4'h0;
endtask

task automatic wait_oe(input int limit, input string what);
    int n;
    n = 0;
    @(negedge sd_datInWrite_clk);
    while (!spi_d_oe) begin
        n++;
        if (n > limit) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            abort_run();
        end
        @(negedge sd_datInWrite_clk);
    end
endtask

// Eight bytes most significant first and oe low right after them
task automatic collect_resp(output resp_t r);
    wait_oe(20, "response bytes");
    for (int i = 0; i < `SDR_RESP_LEN / 8; i++) begin
        expect_flag("spi_d_oe", spi_d_oe, 1'b1);
        r = {r[`SDR_RESP_LEN-9:0], spi_d_out};
        @(negedge sd_datInWrite_clk);
    end
    expect_flag("spi_d_oe", spi_d_oe, 1'b0);    // Exactly 8 bytes
endtask

// ==================================================
// Compare tasks
// ==================================================

task automatic compare_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic compare_word(input string name, input sdr_word_t got, input sdr_word_t exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic compare_led(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
        $display("[FAIL] led: got %h, expected %h", got, exp);
        abort_run();
    end
endtask

task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

`endif

// File: sim/tb_sd_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_readout_params.svh"

module tb_sd_readout
    import sd_readout_pkg::*;
();

    localparam int max_gap    = 3;                            // Idle cycles between SD words
    localparam int block_run  = 2 * `SDR_BLOCK_WORDS + 20;    // Into a third block
    localparam int block_left = 30;                           // Left in the FIFO afterwards
    localparam int fill_run   = `SDR_FIFO_DEPTH - block_left;
    localparam int resume_run = 20;
    localparam int expected_cycles = (block_run + fill_run + resume_run) * (max_gap + 3)
                                     + 20 * 40;

    logic        sd_datInWrite_clk;
    logic        spi_rst_;
    logic        sd_datin_trigger;
    sdr_word_t   sd_datin_data;
    logic        sd_datin_ready;
    logic [3:0]  spi_d_in;
    logic [7:0]  spi_d_out;
    logic        spi_d_oe;
    logic        spi_d_ready;
    logic [3:0]  led;

    logic [31:0] rng_state;
    sdr_word_t   model_q[$];      // Words accepted and not yet read out
    int          model_pos;       // Word index inside current block
    logic [7:0]  model_blocks;
    logic [3:0]  model_mode;
    logic [55:0] arg;

    sd_readout_top dut (.*);

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    `include "tb_checks.svh"

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #50 sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    initial begin
        repeat (4 * expected_cycles) @(posedge sd_datInWrite_clk);
        $display("Watchdog expired after %0d cycles", 4 * expected_cycles);
        abort_run();
    end

    // ==================================================
    // Producer model and SD driver
    // ==================================================

    function automatic void record_word(input sdr_word_t w);
        model_q.push_back(w);
        if (model_pos == `SDR_CMD6_WORD_IDX) model_mode = w[11:8];
        model_pos++;
        if (model_pos == `SDR_BLOCK_WORDS) begin
            model_pos    = 0;
            model_blocks = model_blocks + 8'd1;    // Wraps like the DUT
        end
    endfunction

    // Trigger held with its word until the negedge shows ready
    task automatic send_sd_words(input int count, input bit gaps);
        logic [31:0] rnd;
        int          gap;
        bit          taken;
        @(posedge sd_datInWrite_clk);
        for (int n = 0; n < count; n++) begin
            rnd = rand32();
            gap = gaps ? int'(rnd[31:30]) : 0;
            if (gap > 0) begin
                sd_datin_trigger <= 1'b0;
                repeat (gap) @(posedge sd_datInWrite_clk);
            end
            sd_datin_trigger <= 1'b1;
            sd_datin_data    <= rnd[15:0];
            taken = 1'b0;
            while (!taken) begin
                @(negedge sd_datInWrite_clk);
                taken = sd_datin_ready;
                @(posedge sd_datInWrite_clk);
            end
            record_word(rnd[15:0]);
        end
        sd_datin_trigger <= 1'b0;
    endtask

    task automatic exchange(input logic [7:0] code, input logic [55:0] a, input resp_t exp);
        resp_t r;
        send_msg(code, a);
        collect_resp(r);
        compare_resp("spi_d_out", r, exp);
    endtask

    // High byte then low byte per word and nothing after the last word
    task automatic read_words(input int count);
        sdr_word_t got;
        for (int n = 0; n < count; n++) begin
            wait_oe(2000, "readout data");
            got[15:8] = spi_d_out;
            @(negedge sd_datInWrite_clk);
            expect_flag("spi_d_oe", spi_d_oe, 1'b1);
            got[7:0] = spi_d_out;
            compare_word("spi_d_out", got, model_q.pop_front());
        end
        @(negedge sd_datInWrite_clk);
        expect_flag("spi_d_oe", spi_d_oe, 1'b0);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        rng_state        = 32'h981cfb99;
        spi_rst_         = 1'b0;
        sd_datin_trigger = 1'b0;
        sd_datin_data    = '0;
        spi_d_in         = 4'h0;
        model_pos        = 0;
        model_blocks     = 8'h00;
        model_mode       = 4'h0;
        repeat (4) @(posedge sd_datInWrite_clk);
        spi_rst_ <= 1'b1;
        @(negedge sd_datInWrite_clk);
        expect_flag("spi_d_oe", spi_d_oe, 1'b0);
        expect_flag("sd_datin_ready", sd_datin_ready, 1'b1);
        expect_flag("spi_d_ready", spi_d_ready, 1'b0);
        compare_led(led, 4'h0);
        exchange(msg_sdstatus, rand_arg(), '0);    // Status starts at zero

        repeat (4) begin
            arg = rand_arg();
            exchange(msg_echo, arg, {arg, 8'h00});
            arg = rand_arg();
            exchange(msg_ledset, arg, '0);
            compare_led(led, arg[3:0]);
        end
        exchange(msg_nop, rand_arg(), '0);
        exchange(8'hc5, rand_arg(), '0);    // Unknown code

        // Engine drains while blocks arrive with gaps
        fork
            send_sd_words(block_run, 1'b1);
            begin
                send_msg(msg_readout, 56'(block_run - block_left));
                read_words(block_run - block_left);
            end
        join
        exchange(msg_sdstatus, rand_arg(),
                 {model_mode, model_blocks, 8'(model_q.size()), 44'h0});
        expect_flag("spi_d_ready", spi_d_ready, 1'b0);

        while (model_q.size() < `SDR_FIFO_DEPTH) begin
            send_sd_words(1, 1'b0);
            @(negedge sd_datInWrite_clk);
            @(negedge sd_datInWrite_clk);    // Ready flag is one cycle behind
            expect_flag("spi_d_ready", spi_d_ready, model_q.size() >= `SDR_READ_THRESH);
        end
        expect_flag("sd_datin_ready", sd_datin_ready, 1'b0);

        // Writer starts against a full FIFO
        fork
            send_sd_words(resume_run, 1'b1);
            begin
                send_msg(msg_readout, 56'(`SDR_FIFO_DEPTH + resume_run));
                read_words(`SDR_FIFO_DEPTH + resume_run);
            end
        join
        exchange(msg_sdstatus, rand_arg(), {model_mode, model_blocks, 8'h00, 44'h0});
        expect_flag("spi_d_ready", spi_d_ready, 1'b0);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/datin_block_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_readout_params.svh"

module datin_block_capture
    import sd_readout_pkg::*;
(
    input  logic        sd_datInWrite_clk,
    input  logic        spi_rst_,

    // SD DatIn side
    input  logic        in_valid,
    input  sdr_word_t   in_data,
    output logic        in_ready,

    // Toward the readout FIFO
    output logic        out_valid,
    output datin_beat_t out_beat,
    input  logic        out_ready,

    output sd_status_t  status
);

    localparam int cnt_w = $clog2(`SDR_BLOCK_WORDS);

    logic [cnt_w-1:0] word_cnt;    // Position inside current block
    logic             last_word;
    logic             accept;

    // ==================================================
    // Handshake and forwarding
    // ==================================================

    // FIFO backpressure goes straight to the SD side
    assign in_ready  = out_ready;
    assign accept    = in_valid && out_ready;
    assign last_word = (word_cnt == cnt_w'(`SDR_BLOCK_WORDS - 1));

    assign out_valid     = in_valid;
    assign out_beat.word = in_data;
    assign out_beat.last = last_word;

    // ==================================================
    // Block counting and CMD6 capture
    // ==================================================

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_cnt <= '0;
            status   <= '0;
        end else if (accept) begin
            if (last_word) begin
                word_cnt           <= '0;
                status.block_count <= status.block_count + 8'd1;
            end else begin
                word_cnt <= word_cnt + cnt_w'(1);
            end

            // Access mode lives in one fixed word of every block
            if (word_cnt == cnt_w'(`SDR_CMD6_WORD_IDX)) begin
                status.access_mode <= in_data[`SDR_CMD6_MODE_LSB +: 4];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/qspi_cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_readout_params.svh"

module qspi_cmd_engine
    import sd_readout_pkg::*;
(
    input  logic                                sd_datInWrite_clk,
    input  logic                                spi_rst_,

    // Host lines
    input  logic [3:0]                          spi_d_in,
    output logic [7:0]                          spi_d_out,
    output logic                                spi_d_oe,
    output logic                                spi_d_ready,
    output logic [3:0]                          led,

    // Producer status
    input  sd_status_t                          status,

    // Readout FIFO
    input  logic [$clog2(`SDR_FIFO_DEPTH+1)-1:0] fifo_level,
    input  datin_beat_t                         fifo_data,
    output logic                                fifo_trigger
);

    typedef enum logic [2:0] {
        st_idle,
        st_msg_in,
        st_decode,
        st_resp_out,
        st_rd_high,
        st_rd_low
    } state_e;

    localparam int nib_count  = `SDR_MSG_LEN / 4;     // Four lines in
    localparam int byte_count = `SDR_RESP_LEN / 8;    // Eight lines out
    localparam int cnt_w      = $clog2(nib_count);

    state_e           state;
    logic [cnt_w-1:0] cnt;         // Nibbles or bytes still to go
    msg_t             msg;
    resp_t            resp;
    resp_t            resp_next;
    logic [8:0]       rd_left;     // Readout words remaining
    logic [7:0]       low_byte;

    // ==================================================
    // Host outputs
    // ==================================================

    assign fifo_trigger = (state == st_rd_high) && (fifo_level != '0);

    // Readout stays quiet while the FIFO is empty
    assign spi_d_oe = (state == st_resp_out) || fifo_trigger || (state == st_rd_low);

    always_comb begin
        case (state)
            st_rd_high: spi_d_out = fifo_data.word[15:8];
            st_rd_low:  spi_d_out = low_byte;
            default:    spi_d_out = resp[`SDR_RESP_LEN-1 -: 8];
        endcase
    end

    // Response word for the message just received
    always_comb begin
        resp_next = '0;
        case (msg.msg_type)
            msg_echo: resp_next = {msg.arg, 8'h00};
            msg_sdstatus: begin
                resp_next[`SDR_RESP_LEN-1 -: 20] = {status.access_mode,
                                                    status.block_count,
                                                    8'(fifo_level)};
            end
            default: resp_next = '0;    // LEDSet, Nop, unknown
        endcase
    end

    // ==================================================
    // Control FSM
    // ==================================================

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state       <= st_idle;
            cnt         <= '0;
            rd_left     <= '0;
            led         <= '0;
            spi_d_ready <= 1'b0;
        end else begin
            spi_d_ready <= (fifo_level >= `SDR_READ_THRESH);

            case (state)
                st_idle: begin
                    // Top bit of the type code opens a message
                    if (spi_d_in[3]) begin
                        cnt   <= cnt_w'(nib_count - 2);
                        state <= st_msg_in;
                    end
                end

                st_msg_in: begin
                    if (cnt == '0) begin
                        state <= st_decode;
                    end else begin
                        cnt <= cnt - cnt_w'(1);
                    end
                end

                st_decode: begin
                    cnt   <= cnt_w'(byte_count - 1);
                    state <= st_resp_out;
                    case (msg.msg_type)
                        msg_ledset: led <= msg.arg[3:0];
                        msg_readout: begin
                            rd_left <= msg.arg[8:0];
                            state   <= (msg.arg[8:0] == '0) ? st_idle : st_rd_high;
                        end
                        default: ;
                    endcase
                end

                st_resp_out: begin
                    if (cnt == '0) begin
                        state <= st_idle;
                    end else begin
                        cnt <= cnt - cnt_w'(1);
                    end
                end

                st_rd_high: begin
                    if (fifo_trigger) state <= st_rd_low;    // Else wait for data
                end

                st_rd_low: begin
                    rd_left <= rd_left - 9'd1;
                    state   <= (rd_left == 9'd1) ? st_idle : st_rd_high;
                end

                default: state <= st_idle;
            endcase
        end
    end

    // ==================================================
    // Shift registers
    // ==================================================

    always_ff @(posedge sd_datInWrite_clk) begin
        // High nibble first
        if (state == st_idle || state == st_msg_in) begin
            msg <= msg_t'({msg[`SDR_MSG_LEN-5:0], spi_d_in});
        end

        if (state == st_decode) begin
            resp <= resp_next;
        end else if (state == st_resp_out) begin
            resp <= resp << 8;
        end

        if (fifo_trigger) begin
            low_byte <= fifo_data.word[7:0];    // Popped word's second half
        end
    end

endmodule

`default_nettype wire

// File: src/readout_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module readout_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  depth     = 16
) (
    input  logic                       sd_datInWrite_clk,
    input  logic                       spi_rst_,

    // Write port
    input  logic                       w_valid,
    input  payload_t                   w_data,
    output logic                       w_ready,

    // Read port with first-word fall-through
    input  logic                       r_trigger,
    output payload_t                   r_data,
    output logic [$clog2(depth+1)-1:0] level
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int lvl_w = $clog2(depth + 1);

    payload_t   mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic       do_write;
    logic       do_read;

    assign w_ready  = (level != lvl_w'(depth));
    assign do_write = w_valid && w_ready;
    assign do_read  = r_trigger && (level != '0);    // Empty pops are dropped
    assign r_data   = mem[rd_ptr];

    // Storage
    always_ff @(posedge sd_datInWrite_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= w_data;
        end
    end

    // ==================================================
    // Pointers and occupancy
    // ==================================================

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
            end

            case ({do_write, do_read})
                2'b10:   level <= level + lvl_w'(1);
                2'b01:   level <= level - lvl_w'(1);
                default: level <= level;    // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/sd_readout_params.svh
`ifndef SD_READOUT_PARAMS_SVH
`define SD_READOUT_PARAMS_SVH

// ==================================================
// Data path widths
// ==================================================

// DatIn and FIFO word width
`define SDR_WORD_W 16

// Host message and response lengths in bits
`define SDR_MSG_LEN 64
`define SDR_RESP_LEN 64

// ==================================================
// SD block layout
// ==================================================

// 512-byte block, 16 bits per word
`define SDR_BLOCK_WORDS 256

// CMD6 status word carrying the access mode
`define SDR_CMD6_WORD_IDX 8
`define SDR_CMD6_MODE_LSB 8    // Mode sits in bits 11:8

// ==================================================
// Readout FIFO
// ==================================================

`define SDR_FIFO_DEPTH 64      // Words

// Level where host ready goes high
`define SDR_READ_THRESH 32

`endif

// File: src/sd_readout_pkg.sv
`default_nettype none

`include "sd_readout_params.svh"

package sd_readout_pkg;

    // ==================================================
    // Data words
    // ==================================================

    typedef logic [`SDR_WORD_W-1:0] sdr_word_t;

    // One word on its way from the SD side into the FIFO
    typedef struct packed {
        sdr_word_t word;
        logic      last;    // Final word of a 512-byte block
    } datin_beat_t;

    // Producer status seen by the host
    typedef struct packed {
        logic [3:0] access_mode;    // From CMD6 status word
        logic [7:0] block_count;    // Wraps at 256
    } sd_status_t;

    // ==================================================
    // Host messages
    // ==================================================

    // Every code has its top bit set, which marks the first nibble
    typedef enum logic [7:0] {
        msg_echo     = 8'h80,
        msg_ledset   = 8'h81,
        msg_sdstatus = 8'h82,
        msg_readout  = 8'h83,
        msg_nop      = 8'hff
    } msg_type_e;

    typedef struct packed {
        msg_type_e                msg_type;
        logic [`SDR_MSG_LEN-9:0]  arg;
    } msg_t;

    // Sent back most significant byte first
    typedef logic [`SDR_RESP_LEN-1:0] resp_t;

endpackage

`default_nettype wire

// File: src/sd_readout_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_readout_params.svh"

module sd_readout_top
    import sd_readout_pkg::*;
(
    input  logic        sd_datInWrite_clk,
    input  logic        spi_rst_,

    // SD DatIn stream
    input  logic        sd_datin_trigger,
    input  sdr_word_t   sd_datin_data,
    output logic        sd_datin_ready,

    // Host port
    input  logic [3:0]  spi_d_in,
    output logic [7:0]  spi_d_out,
    output logic        spi_d_oe,
    output logic        spi_d_ready,
    output logic [3:0]  led
);

    datin_beat_t fifo_w_beat;
    logic        fifo_w_valid;
    logic        fifo_w_ready;
    datin_beat_t fifo_r_data;
    logic        fifo_r_trigger;
    logic [$clog2(`SDR_FIFO_DEPTH+1)-1:0] fifo_level;
    sd_status_t  sd_status;

    // ==================================================
    // Producer, buffer, consumer
    // ==================================================

    datin_block_capture u_capture (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .in_valid          (sd_datin_trigger),
        .in_data           (sd_datin_data),
        .in_ready          (sd_datin_ready),
        .out_valid         (fifo_w_valid),
        .out_beat          (fifo_w_beat),
        .out_ready         (fifo_w_ready),
        .status            (sd_status)
    );

    readout_fifo #(
        .payload_t (datin_beat_t),
        .depth     (`SDR_FIFO_DEPTH)
    ) u_fifo (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .w_valid           (fifo_w_valid),
        .w_data            (fifo_w_beat),
        .w_ready           (fifo_w_ready),
        .r_trigger         (fifo_r_trigger),
        .r_data            (fifo_r_data),
        .level             (fifo_level)
    );

    qspi_cmd_engine u_engine (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_d_in          (spi_d_in),
        .spi_d_out         (spi_d_out),
        .spi_d_oe          (spi_d_oe),
        .spi_d_ready       (spi_d_ready),
        .led               (led),
        .status            (sd_status),
        .fifo_level        (fifo_level),
        .fifo_data         (fifo_r_data),
        .fifo_trigger      (fifo_r_trigger)
    );

endmodule

`default_nettype wire
